/* hdl/spi_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        cpol,
    input  logic [15:0] clk_div,
    output logic        spi_clk,
    output logic        lead_tick,
    output logic        trail_tick
);

    logic [15:0] div_cnt;
    logic        clk_q;
    logic        clk_dly;
    logic        edge_seen;

    // ------------------------------
    // Divider and serial clock
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            clk_q   <= 1'b0;
            clk_dly <= 1'b0;
        end else if (!run) begin
            // Park both copies at the idle level so no edge is seen on start
            div_cnt <= '0;
            clk_q   <= cpol;
            clk_dly <= cpol;
        end else begin
            clk_dly <= clk_q;
            if (div_cnt == clk_div) begin
                div_cnt <= '0;
                clk_q   <= ~clk_q;
            end else begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

    // Idle level follows cpol directly while stopped
    assign spi_clk = run ? clk_q : cpol;

    // Edge ticks, one cycle after the toggle
    assign edge_seen  = run & (clk_q ^ clk_dly);

    // Leading moves away from idle, trailing returns to it
    assign lead_tick  = edge_seen & (clk_q != cpol);
    assign trail_tick = edge_seen & (clk_q == cpol);

endmodule

`default_nettype wire

/* hdl/spi_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface spi_cmd_if #(
    parameter int NUM_SLAVES = 4,
    parameter int DATA_WIDTH = 8
);
    import spi_pkg::*;

    // Head of the command queue
    logic                          valid;
    logic [DATA_WIDTH-1:0]         data;
    logic [$clog2(NUM_SLAVES)-1:0] slave;
    spi_mode_t                     mode;

    // Consumes the head in the same cycle, only legal while valid
    logic                          take;

    modport source (
        output valid,
        output data,
        output slave,
        output mode,
        input  take
    );

    modport sink (
        input  valid,
        input  data,
        input  slave,
        input  mode,
        output take
    );

endinterface

`default_nettype wire

/* hdl/spi_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_queue #(
    parameter int NUM_SLAVES  = 4,
    parameter int DATA_WIDTH  = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    input  logic [DATA_WIDTH-1:0]         cmd_data,
    input  logic [$clog2(NUM_SLAVES)-1:0] cmd_slave,
    input  spi_pkg::spi_mode_t            cmd_mode,
    output logic                          credit_return,
    spi_cmd_if.source                     deq
);
    import spi_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Storage, one slot per host credit
    logic [DATA_WIDTH-1:0]         data_mem  [QUEUE_DEPTH];
    logic [$clog2(NUM_SLAVES)-1:0] slave_mem [QUEUE_DEPTH];
    spi_mode_t                     mode_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at QUEUE_DEPTH so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------
    // Pointers, occupancy and credits
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq.take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({cmd_valid, deq.take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Freed slot goes back to the host one cycle after the take
            credit_return <= deq.take;
        end
    end

    // Credited writes never find the queue full
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            data_mem[wr_ptr]  <= cmd_data;
            slave_mem[wr_ptr] <= cmd_slave;
            mode_mem[wr_ptr]  <= cmd_mode;
        end
    end

    // Head of queue
    assign deq.valid = (count != '0);
    assign deq.data  = data_mem[rd_ptr];
    assign deq.slave = slave_mem[rd_ptr];
    assign deq.mode  = mode_mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/spi_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_top #(
    parameter int NUM_SLAVES  = 4,
    parameter int DATA_WIDTH  = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // Host command side, credit based
    input  logic                          cmd_valid,
    input  logic [DATA_WIDTH-1:0]         cmd_data,
    input  logic [$clog2(NUM_SLAVES)-1:0] cmd_slave,
    input  spi_pkg::spi_mode_t            cmd_mode,
    output logic                          credit_return,
    input  logic [15:0]                   clk_div,

    // Host result side
    output logic                          result_valid,
    output logic [DATA_WIDTH-1:0]         result_data,
    output logic [$clog2(NUM_SLAVES)-1:0] result_slave,
    output logic                          busy,

    // SPI bus
    output logic                          spi_clk,
    output logic                          spi_mosi,
    input  logic                          spi_miso,
    output logic [NUM_SLAVES-1:0]         spi_cs_n
);

    logic run;
    logic cpol;
    logic lead_tick;
    logic trail_tick;

    spi_cmd_if #(
        .NUM_SLAVES (NUM_SLAVES),
        .DATA_WIDTH (DATA_WIDTH)
    ) cmd_bus ();

    spi_cmd_queue #(
        .NUM_SLAVES  (NUM_SLAVES),
        .DATA_WIDTH  (DATA_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_data      (cmd_data),
        .cmd_slave     (cmd_slave),
        .cmd_mode      (cmd_mode),
        .credit_return (credit_return),
        .deq           (cmd_bus.source)
    );

    spi_clock_gen u_clock_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .cpol       (cpol),
        .clk_div    (clk_div),
        .spi_clk    (spi_clk),
        .lead_tick  (lead_tick),
        .trail_tick (trail_tick)
    );

    spi_shift_engine #(
        .NUM_SLAVES (NUM_SLAVES),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd_bus.sink),
        .lead_tick    (lead_tick),
        .trail_tick   (trail_tick),
        .run          (run),
        .cpol         (cpol),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_slave (result_slave),
        .spi_mosi     (spi_mosi),
        .spi_cs_n     (spi_cs_n),
        .spi_miso     (spi_miso)
    );

endmodule

`default_nettype wire

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

    // ------------------------------
    // SPI mode, CPOL in bit 1 and CPHA in bit 0
    // ------------------------------
    typedef enum logic [1:0] {
        MODE0 = 2'b00,
        MODE1 = 2'b01,
        MODE2 = 2'b10,
        MODE3 = 2'b11
    } spi_mode_t;

    // Shift engine states
    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        SHIFT,
        FINISH
    } spi_state_t;

    // Idle level of the serial clock
    function automatic logic mode_cpol(input spi_mode_t mode);
        return mode[1];
    endfunction

    // Set means data is sampled on the trailing edge
    function automatic logic mode_cpha(input spi_mode_t mode);
        return mode[0];
    endfunction

endpackage

`default_nettype wire

/* hdl/spi_shift_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
    parameter int NUM_SLAVES = 4,
    parameter int DATA_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    spi_cmd_if.sink                       cmd,
    input  logic                          lead_tick,
    input  logic                          trail_tick,
    output logic                          run,
    output logic                          cpol,
    output logic                          busy,
    output logic                          result_valid,
    output logic [DATA_WIDTH-1:0]         result_data,
    output logic [$clog2(NUM_SLAVES)-1:0] result_slave,
    output logic                          spi_mosi,
    output logic [NUM_SLAVES-1:0]         spi_cs_n,
    input  logic                          spi_miso
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    spi_state_t                    state;
    spi_mode_t                     mode_q;
    logic [$clog2(NUM_SLAVES)-1:0] slave_q;
    logic [DATA_WIDTH-1:0]         data_q;
    logic [DATA_WIDTH-1:0]         tx_q;
    logic [DATA_WIDTH-1:0]         rx_q;
    logic [CNT_W-1:0]              bit_cnt;

    logic cpha;
    logic sample_tick;
    logic setup_tick;
    logic shift_tx;
    logic last_sample;

    // ------------------------------
    // Edge decode per phase
    // ------------------------------
    assign cpha        = mode_cpha(mode_q);
    assign sample_tick = (state == SHIFT) & (cpha ? trail_tick : lead_tick);
    assign setup_tick  = (state == SHIFT) & (cpha ? lead_tick : trail_tick);

    // First leading edge in phase 1 only presents the MSB
    assign shift_tx    = setup_tick & ~(cpha & (bit_cnt == '0));
    assign last_sample = sample_tick & (bit_cnt == CNT_W'(DATA_WIDTH - 1));

    // Queue handshake, head consumed as soon as the engine is idle
    assign cmd.take = (state == IDLE) & cmd.valid;

    // ------------------------------
    // FSM and control state
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            mode_q   <= MODE0;
            spi_cs_n <= '1;
            bit_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd.take) begin
                        mode_q   <= cmd.mode;
                        spi_cs_n <= ~(NUM_SLAVES'(1) << cmd.slave);
                        state    <= SELECT;
                    end
                end
                SELECT: begin
                    bit_cnt <= '0;
                    state   <= SHIFT;
                end
                SHIFT: begin
                    if (sample_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (last_sample) begin
                        spi_cs_n <= '1;
                        state    <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latched command and shift registers
    always_ff @(posedge clk) begin
        if (cmd.take) begin
            data_q  <= cmd.data;
            slave_q <= cmd.slave;
        end
        if (state == SELECT) begin
            tx_q <= data_q;
        end else if (shift_tx) begin
            tx_q <= {tx_q[DATA_WIDTH-2:0], 1'b0};
        end
        if (sample_tick) begin
            rx_q <= {rx_q[DATA_WIDTH-2:0], spi_miso};
        end
    end

    // New polarity shows up in the take cycle, one cycle ahead of chip select
    assign cpol = cmd.take ? mode_cpol(cmd.mode) : mode_cpol(mode_q);
    assign run  = (state == SHIFT);
    assign busy = (state != IDLE) | cmd.take;

    assign spi_mosi     = tx_q[DATA_WIDTH-1];
    assign result_valid = (state == FINISH);
    assign result_data  = rx_q;
    assign result_slave = slave_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module spi_master_tb -o spi_sim \
    && ./obj_dir/spi_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* sim.f */
hdl/spi_pkg.sv
hdl/spi_cmd_if.sv
hdl/spi_cmd_queue.sv
hdl/spi_clock_gen.sv
hdl/spi_shift_engine.sv
hdl/spi_master_top.sv
testbench/spi_master_checker.sv
testbench/spi_master_tb.sv

/* testbench/spi_master_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_checker #(
    parameter int NUM_SLAVES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_SLAVES-1:0]  spi_cs_n,
    input  logic                   lead_tick,
    input  logic                   trail_tick,
    input  spi_pkg::spi_state_t    state,
    input  logic                   result_valid
);
    import spi_pkg::*;

    // At most one slave selected at any time
    cs_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~spi_cs_n))
        else $error("more than one chip select is low");

    // Serial clock stays parked while no slave is selected
    clk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (spi_cs_n == '1) |-> !(lead_tick || trail_tick))
        else $error("serial clock edge with no chip select low");

    // Shifting only with a slave selected
    shift_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SHIFT) |-> (spi_cs_n != '1))
        else $error("shift state with all chip selects high");

    result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

endmodule

bind spi_shift_engine spi_master_checker #(
    .NUM_SLAVES (NUM_SLAVES)
) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_cs_n     (spi_cs_n),
    .lead_tick    (lead_tick),
    .trail_tick   (trail_tick),
    .state        (state),
    .result_valid (result_valid)
);

`default_nettype wire

/* testbench/spi_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;
    import spi_pkg::*;

    localparam int NUM_SLAVES  = 4;
    localparam int DATA_WIDTH  = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int SW          = $clog2(NUM_SLAVES);
    localparam int BATCHES     = 6;
    localparam int PER_BATCH   = 12;
    localparam int TIMEOUT     = 20000;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_valid;
    logic [DATA_WIDTH-1:0] cmd_data;
    logic [SW-1:0]         cmd_slave;
    spi_mode_t             cmd_mode;
    logic                  credit_return;
    logic [15:0]           clk_div;
    logic                  result_valid;
    logic [DATA_WIDTH-1:0] result_data;
    logic [SW-1:0]         result_slave;
    logic                  busy;
    logic                  spi_clk;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic [NUM_SLAVES-1:0] spi_cs_n;

    integer seed       = 80405;
    integer slave_seed = 80405;
    int     errors     = 0;
    int     credits    = QUEUE_DEPTH;
    int     sent       = 0;
    int     returned   = 0;
    int     results    = 0;

    // Reference model, one entry per command in flight
    logic [DATA_WIDTH-1:0] exp_data  [$];
    logic [SW-1:0]         exp_slave [$];
    spi_mode_t             exp_mode  [$];
    logic [DATA_WIDTH-1:0] got_mosi  [$];
    logic [DATA_WIDTH-1:0] got_resp  [$];

    spi_master_top #(
        .NUM_SLAVES  (NUM_SLAVES),
        .DATA_WIDTH  (DATA_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_data      (cmd_data),
        .cmd_slave     (cmd_slave),
        .cmd_mode      (cmd_mode),
        .credit_return (credit_return),
        .clk_div       (clk_div),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_slave  (result_slave),
        .busy          (busy),
        .spi_clk       (spi_clk),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .spi_cs_n      (spi_cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Error handling and compares
    // ------------------------------
    task automatic stop_run(input string what);
        errors++;
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_slave(input string name, input logic [SW-1:0] exp,
                               input logic [SW-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_mode(input string name, input spi_mode_t exp, input spi_mode_t act);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    function automatic logic [SW-1:0] low_index(input logic [NUM_SLAVES-1:0] cs);
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (!cs[i]) begin
                return SW'(i);
            end
        end
        return '0;
    endfunction

    // One falling edge, credits counted on the way
    task automatic step();
        @(negedge clk);
        if (credit_return) begin
            if (credits >= QUEUE_DEPTH) begin
                stop_run("credit returned while the host holds all credits");
            end
            credits++;
            returned++;
        end
    endtask

    // ------------------------------
    // SPI slave model and result check
    // ------------------------------
    logic                  active = 1'b0;
    logic                  prev_clk;
    logic                  idle_clk;
    logic [1:0]            cur_mode;
    logic [NUM_SLAVES-1:0] cur_cs;
    logic [DATA_WIDTH-1:0] resp_word;
    logic [DATA_WIDTH-1:0] rx_word;
    int                    out_idx;
    int                    sample_cnt;

    always @(negedge clk) begin
        logic lead;
        logic trail;
        if (rst_n && (spi_cs_n != '1 || result_valid) && !busy) begin
            stop_run("busy low during a transfer");
        end
        if (rst_n && exp_data.size() == 0 && busy) begin
            stop_run("busy high with no command outstanding");
        end
        if (rst_n && !active && spi_cs_n != '1) begin
            if (exp_mode.size() == 0) begin
                stop_run("chip select fell with no command outstanding");
            end
            cur_mode  = exp_mode[0];
            cur_cs    = spi_cs_n;
            check_slave("chip_select", exp_slave[0], low_index(spi_cs_n));
            if (spi_cs_n != ~(NUM_SLAVES'(1) << exp_slave[0])) begin
                stop_run("more than the addressed chip select is low");
            end
            idle_clk   = spi_clk;
            resp_word  = DATA_WIDTH'($random(slave_seed));
            rx_word    = '0;
            sample_cnt = 0;
            prev_clk   = spi_clk;
            active     = 1'b1;
            // Phase 0 puts the MSB out at chip select fall
            if (!cur_mode[0]) begin
                spi_miso = resp_word[DATA_WIDTH-1];
                out_idx  = DATA_WIDTH - 2;
            end else begin
                out_idx = DATA_WIDTH - 1;
            end
        end else if (active && spi_cs_n == '1) begin
            if (sample_cnt != DATA_WIDTH) begin
                stop_run("wrong number of serial clock sample edges");
            end
            // Phase 1 ends back at idle, phase 0 ends on a leading edge
            check_mode("mode_seen", spi_mode_t'(cur_mode),
                       spi_mode_t'({idle_clk, prev_clk == idle_clk}));
            got_mosi.push_back(rx_word);
            got_resp.push_back(resp_word);
            active = 1'b0;
        end else if (active) begin
            if (spi_cs_n != cur_cs) begin
                stop_run("chip select changed during a transfer");
            end
            lead  = (spi_clk != prev_clk) && (spi_clk != cur_mode[1]);
            trail = (spi_clk != prev_clk) && (spi_clk == cur_mode[1]);
            prev_clk = spi_clk;
            if ((cur_mode[0] ? trail : lead)) begin
                rx_word = {rx_word[DATA_WIDTH-2:0], spi_mosi};
                sample_cnt++;
            end
            if ((cur_mode[0] ? lead : trail) && out_idx >= 0) begin
                spi_miso = resp_word[out_idx];
                out_idx--;
            end
        end

        if (result_valid) begin
            if (exp_data.size() == 0 || got_mosi.size() == 0) begin
                stop_run("result with no matching command or transfer");
            end
            check_word("mosi_word", exp_data.pop_front(), got_mosi.pop_front());
            check_word("miso_word", got_resp.pop_front(), result_data);
            check_slave("result_slave", exp_slave.pop_front(), result_slave);
            void'(exp_mode.pop_front());
            results++;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_batch(input int count);
        int n;
        int cycles;
        n      = 0;
        cycles = 0;
        while (n < count) begin
            step();
            cmd_valid = 1'b0;
            if (credits > 0 && $random(seed) % 2 != 0) begin
                cmd_valid = 1'b1;
                cmd_data  = DATA_WIDTH'($random(seed));
                cmd_slave = SW'($random(seed));
                cmd_mode  = spi_mode_t'(2'($random(seed)));
                exp_data.push_back(cmd_data);
                exp_slave.push_back(cmd_slave);
                exp_mode.push_back(cmd_mode);
                credits--;
                sent++;
                n++;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout while waiting for a credit");
            end
        end
        step();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (results != sent || credits != QUEUE_DEPTH || busy) begin
            step();
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout while waiting for the queue to drain");
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        cmd_slave = '0;
        cmd_mode  = MODE0;
        clk_div   = 16'd1;
        spi_miso  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int b = 0; b < BATCHES; b++) begin
            clk_div = 16'(1 + ($unsigned($random(seed)) % 5));
            send_batch(PER_BATCH);
            wait_drain();
        end

        if (returned != sent) begin
            stop_run("credit returns do not match commands sent");
        end
        if (exp_data.size() != 0 || got_mosi.size() != 0) begin
            stop_run("commands left without a result");
        end

        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
